// File: hdl/mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] word_t;	// Data or address word
	typedef logic [4:0] reg_addr_t;	// Register index
	typedef logic [5:0] opcode_t;	// Primary opcode field
	typedef logic [5:0] funct_t;	// R-type function field

	// Primary opcodes
	localparam opcode_t op_rtype = 6'b000000;	// Decoded further on funct
	localparam opcode_t op_j     = 6'b000010;
	localparam opcode_t op_jal   = 6'b000011;
	localparam opcode_t op_beq   = 6'b000100;
	localparam opcode_t op_bne   = 6'b000101;
	localparam opcode_t op_addiu = 6'b001001;
	localparam opcode_t op_slti  = 6'b001010;
	localparam opcode_t op_sltiu = 6'b001011;
	localparam opcode_t op_andi  = 6'b001100;
	localparam opcode_t op_ori   = 6'b001101;
	localparam opcode_t op_xori  = 6'b001110;
	localparam opcode_t op_lui   = 6'b001111;
	localparam opcode_t op_lw    = 6'b100011;
	localparam opcode_t op_sw    = 6'b101011;

	// R-type function codes
	localparam funct_t fn_sll  = 6'b000000;
	localparam funct_t fn_srl  = 6'b000010;
	localparam funct_t fn_sra  = 6'b000011;
	localparam funct_t fn_jr   = 6'b001000;
	localparam funct_t fn_addu = 6'b100001;
	localparam funct_t fn_subu = 6'b100011;
	localparam funct_t fn_and  = 6'b100100;
	localparam funct_t fn_or   = 6'b100101;
	localparam funct_t fn_xor  = 6'b100110;
	localparam funct_t fn_slt  = 6'b101010;
	localparam funct_t fn_sltu = 6'b101011;

	typedef enum logic [3:0] {
		alu_add,	// Also address generation
		alu_sub,	// Also branch compare
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,	// Signed compare
		alu_sltu,	// Unsigned compare
		alu_sll,
		alu_srl,
		alu_sra,
		alu_lui	// Immediate into upper half
	} alu_op_t;

	localparam word_t reset_vector = 32'hBFC00000;	// Boot ROM start

endpackage

// File: hdl/mips_decoder.sv
`timescale 1ns/10ps

module mips_decoder (
	input mips_pkg::opcode_t opcode,
	input mips_pkg::funct_t funct,
	output logic reg_write,	// Register file write
	output logic reg_dst,	// Write to rd, else rt
	output logic alu_src_imm,	// ALU b from immediate
	output logic zero_ext,	// Logic immediates zero extended
	output logic shift_imm,	// Shift amount from instruction
	output logic mem_to_reg,	// Writeback from data memory
	output logic mem_read,
	output logic mem_write,
	output logic branch_eq,
	output logic branch_ne,
	output logic jump,	// J and JAL
	output logic jump_reg,	// JR
	output logic link,	// Write pc_plus4 to r31
	output mips_pkg::alu_op_t alu_op
);
	import mips_pkg::*;

	always_comb begin
		reg_write = 1'b0;	// Defaults give a no-operation
		reg_dst = 1'b0;
		alu_src_imm = 1'b0;
		zero_ext = 1'b0;
		shift_imm = 1'b0;
		mem_to_reg = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		branch_eq = 1'b0;
		branch_ne = 1'b0;
		jump = 1'b0;
		jump_reg = 1'b0;
		link = 1'b0;
		alu_op = alu_add;
		case (opcode)
			op_rtype: begin
				reg_write = 1'b1;	// Cleared again for JR and unknown funct
				reg_dst = 1'b1;
				case (funct)
					fn_addu: alu_op = alu_add;
					fn_subu: alu_op = alu_sub;
					fn_and: alu_op = alu_and;
					fn_or: alu_op = alu_or;
					fn_xor: alu_op = alu_xor;
					fn_slt: alu_op = alu_slt;
					fn_sltu: alu_op = alu_sltu;
					fn_sll: begin
						alu_op = alu_sll;
						shift_imm = 1'b1;
					end
					fn_srl: begin
						alu_op = alu_srl;
						shift_imm = 1'b1;
					end
					fn_sra: begin
						alu_op = alu_sra;
						shift_imm = 1'b1;
					end
					fn_jr: begin
						reg_write = 1'b0;	// No link in this subset
						reg_dst = 1'b0;
						jump_reg = 1'b1;
					end
					default: begin
						reg_write = 1'b0;	// Unknown funct, nop
						reg_dst = 1'b0;
					end
				endcase
			end
			op_addiu: begin
				reg_write = 1'b1;
				alu_src_imm = 1'b1;
			end
			op_slti, op_sltiu: begin
				reg_write = 1'b1;
				alu_src_imm = 1'b1;
				alu_op = (opcode == op_slti) ? alu_slt : alu_sltu;
			end
			op_andi, op_ori, op_xori: begin
				reg_write = 1'b1;
				alu_src_imm = 1'b1;
				zero_ext = 1'b1;	// Logic ops take unsigned immediate
				alu_op = (opcode == op_andi) ? alu_and :
					(opcode == op_ori) ? alu_or : alu_xor;
			end
			op_lui: begin
				reg_write = 1'b1;
				alu_src_imm = 1'b1;
				alu_op = alu_lui;
			end
			op_lw: begin
				reg_write = 1'b1;
				alu_src_imm = 1'b1;	// Base plus offset
				mem_to_reg = 1'b1;
				mem_read = 1'b1;
			end
			op_sw: begin
				alu_src_imm = 1'b1;
				mem_write = 1'b1;
			end
			op_beq: begin
				branch_eq = 1'b1;
				alu_op = alu_sub;	// Zero flag on equal
			end
			op_bne: begin
				branch_ne = 1'b1;
				alu_op = alu_sub;
			end
			op_j: jump = 1'b1;
			op_jal: begin
				jump = 1'b1;
				link = 1'b1;
				reg_write = 1'b1;	// Return address to r31
			end
			default: ;	// Unknown opcode, nop
		endcase
	end

endmodule

// File: hdl/mips_regfile.sv
`timescale 1ns/10ps

module mips_regfile (
	input logic clk,
	input logic we,
	input mips_pkg::reg_addr_t ra1,
	input mips_pkg::reg_addr_t ra2,
	input mips_pkg::reg_addr_t wa,
	input mips_pkg::word_t wd,
	output mips_pkg::word_t rd1,
	output mips_pkg::word_t rd2,
	output mips_pkg::word_t v0
);
	import mips_pkg::*;

	word_t regs [0:31];	// r0 entry never written

	always_ff @(posedge clk) begin
		if (we && wa != 5'd0) begin
			regs[wa] <= wd;	// Visible to reads next cycle
		end
	end

	// Combinational reads, r0 forced to zero
	assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

	assign v0 = regs[2];	// Observation tap

endmodule

// File: hdl/mips_alu.sv
`timescale 1ns/10ps

module mips_alu (
	input mips_pkg::alu_op_t alu_op,
	input mips_pkg::word_t a,
	input mips_pkg::word_t b,
	input logic [4:0] shamt,
	output mips_pkg::word_t result,
	output logic zero
);
	import mips_pkg::*;

	logic lt_signed;	// a < b as two's complement
	logic lt_unsigned;

	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (alu_op)
			alu_add: result = a + b;	// Wraps, no overflow trap
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or: result = a | b;
			alu_xor: result = a ^ b;
			alu_slt: result = {31'd0, lt_signed};
			alu_sltu: result = {31'd0, lt_unsigned};
			alu_sll: result = b << shamt;	// Shifts act on b
			alu_srl: result = b >> shamt;
			alu_sra: result = $signed(b) >>> shamt;	// Sign fill
			alu_lui: result = {b[15:0], 16'd0};
			default: result = a + b;	// Unused encodings
		endcase
	end

	assign zero = (result == '0);	// Used for BEQ and BNE

endmodule

// File: hdl/mips_fetch.sv
`timescale 1ns/10ps

module mips_fetch #(
	parameter mips_pkg::word_t reset_pc = mips_pkg::reset_vector
) (
	input logic clk,
	input logic reset,
	input logic clk_enable,
	input logic branch_taken,	// Branch condition met
	input logic jump,
	input logic jump_reg,
	input logic [15:0] imm,	// Branch offset in words
	input logic [25:0] target,	// Jump target in words
	input mips_pkg::word_t rs_value,	// JR destination
	output mips_pkg::word_t pc,
	output mips_pkg::word_t pc_plus4,
	output logic active
);
	import mips_pkg::*;

	word_t branch_offset;
	word_t jump_addr;
	word_t next_pc;
	logic halt;	// JR to address zero

	assign pc_plus4 = pc + 32'd4;
	assign branch_offset = {{14{imm[15]}}, imm, 2'b00};
	assign jump_addr = {pc_plus4[31:28], target, 2'b00};	// Same 256MB region
	assign halt = jump_reg && (rs_value == '0);

	// JR over jump over branch, no delay slot
	assign next_pc = jump_reg ? rs_value :
		jump ? jump_addr :
		branch_taken ? pc_plus4 + branch_offset : pc_plus4;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= reset_pc;
			active <= 1'b1;
		end else if (clk_enable && active) begin
			if (halt) begin
				active <= 1'b0;	// PC stays on the JR
			end else begin
				pc <= next_pc;
			end
		end
	end

endmodule

// File: hdl/mips_cpu.sv
`timescale 1ns/10ps

module mips_cpu #(
	parameter mips_pkg::word_t reset_pc = mips_pkg::reset_vector
) (
	input logic clk,
	input logic reset,
	input logic clk_enable,
	output logic active,
	output mips_pkg::word_t register_v0,
	output mips_pkg::word_t instr_address,	// Current PC
	input mips_pkg::word_t instr_readdata,	// Same-cycle instruction
	output mips_pkg::word_t data_address,	// ALU result
	output logic data_write,
	output logic data_read,
	output mips_pkg::word_t data_writedata,	// rt value
	input mips_pkg::word_t data_readdata
);
	import mips_pkg::*;

	logic reg_write, reg_dst, alu_src_imm, zero_ext, shift_imm;
	logic mem_to_reg, mem_read, mem_write, branch_eq, branch_ne;
	logic jump, jump_reg, link, zero, branch_taken, step;
	alu_op_t alu_op;
	reg_addr_t rs, rt, rd, write_reg;
	word_t pc, pc_plus4, rs_value, rt_value, imm_ext, alu_b, alu_result, write_data;
	logic [4:0] shamt;

	assign rs = instr_readdata[25:21];
	assign rt = instr_readdata[20:16];
	assign rd = instr_readdata[15:11];
	assign step = clk_enable && active;	// Cycle retires an instruction

	mips_fetch #(.reset_pc(reset_pc)) i_fetch (
		.clk(clk), .reset(reset), .clk_enable(clk_enable),
		.branch_taken(branch_taken), .jump(jump), .jump_reg(jump_reg),
		.imm(instr_readdata[15:0]), .target(instr_readdata[25:0]),
		.rs_value(rs_value), .pc(pc), .pc_plus4(pc_plus4), .active(active)
	);

	mips_decoder i_decoder (
		.opcode(instr_readdata[31:26]), .funct(instr_readdata[5:0]),
		.reg_write(reg_write), .reg_dst(reg_dst), .alu_src_imm(alu_src_imm),
		.zero_ext(zero_ext), .shift_imm(shift_imm), .mem_to_reg(mem_to_reg),
		.mem_read(mem_read), .mem_write(mem_write), .branch_eq(branch_eq),
		.branch_ne(branch_ne), .jump(jump), .jump_reg(jump_reg), .link(link),
		.alu_op(alu_op)
	);

	mips_regfile i_regfile (
		.clk(clk), .we(reg_write && step), .ra1(rs), .ra2(rt), .wa(write_reg),
		.wd(write_data), .rd1(rs_value), .rd2(rt_value), .v0(register_v0)
	);

	// Operand selection
	assign imm_ext = zero_ext ? {16'd0, instr_readdata[15:0]} :
		{{16{instr_readdata[15]}}, instr_readdata[15:0]};
	assign alu_b = alu_src_imm ? imm_ext : rt_value;
	assign shamt = shift_imm ? instr_readdata[10:6] : 5'd0;	// No variable shifts

	mips_alu i_alu (
		.alu_op(alu_op), .a(rs_value), .b(alu_b), .shamt(shamt),
		.result(alu_result), .zero(zero)
	);

	assign branch_taken = (branch_eq && zero) || (branch_ne && !zero);

	// Writeback selection
	assign write_reg = link ? 5'd31 : (reg_dst ? rd : rt);
	assign write_data = link ? pc_plus4 : (mem_to_reg ? data_readdata : alu_result);

	// Data port
	assign instr_address = pc;
	assign data_address = alu_result;
	assign data_writedata = rt_value;
	assign data_write = mem_write && step;	// Held low when stalled or halted
	assign data_read = mem_read && step;

endmodule

// File: verification/mips_cpu_properties.sv
`timescale 1ns/10ps

module mips_cpu_properties (
	input logic clk,
	input logic reset,
	input logic clk_enable,
	input logic active,
	input mips_pkg::word_t instr_address,
	input logic data_write,
	input logic data_read
);

	strobe_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(data_write && data_read))
		else $error("data_write and data_read high in the same cycle");

	strobe_gated: assert property (@(posedge clk) disable iff (reset)
		(data_write || data_read) |-> (clk_enable && active))
		else $error("data strobe high while stalled or halted");

	pc_aligned: assert property (@(posedge clk) disable iff (reset)
		instr_address[1:0] == 2'b00)	// Word fetches only
		else $error("instr_address not word aligned");

	halt_frozen: assert property (@(posedge clk) disable iff (reset)
		!active |=> $stable(instr_address))
		else $error("instr_address moved while halted");

endmodule

bind mips_cpu mips_cpu_properties i_properties (
	.clk(clk), .reset(reset), .clk_enable(clk_enable), .active(active),
	.instr_address(instr_address), .data_write(data_write), .data_read(data_read)
);

// File: verification/mips_cpu_tb.sv
`timescale 1ns/10ps

module mips_cpu_tb;
	import mips_pkg::*;

	localparam int table_len = 27;	// Program rows from the reset vector
	localparam int halt_row = 26;	// jr r0
	localparam int watchdog_ns = table_len * 4 * 20;

	logic clk = 1'b0;
	logic reset, clk_enable, active, data_write, data_read;
	word_t register_v0, instr_address, instr_readdata;
	word_t data_address, data_writedata, data_readdata;

	word_t prog [0:table_len-1];	// Instruction per row
	logic exp_write [0:table_len-1];
	logic exp_read [0:table_len-1];
	word_t exp_addr [0:table_len-1];
	word_t exp_wdata [0:table_len-1];
	word_t exp_v0 [0:table_len-1];	// register_v0 after the edge
	integer exp_next [0:table_len-1];	// Row fetched after the edge
	logic skipped [0:table_len-1];	// Must never be fetched
	word_t dmem [0:15];
	integer errors;
	integer seed;

	mips_cpu #(.reset_pc(mips_pkg::reset_vector)) i_dut (
		.clk(clk), .reset(reset), .clk_enable(clk_enable), .active(active),
		.register_v0(register_v0), .instr_address(instr_address),
		.instr_readdata(instr_readdata), .data_address(data_address),
		.data_write(data_write), .data_read(data_read),
		.data_writedata(data_writedata), .data_readdata(data_readdata)
	);

	always #10 clk = ~clk;	// 20 ns period

	always @(posedge clk) begin
		if (data_write) begin
			dmem[data_address[5:2]] <= data_writedata;	// Word store
		end
	end

	function automatic word_t encode_itype(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t encode_rtype(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t encode_jtype(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	task fill_row(input integer idx, input word_t instr, input word_t v0, input integer next);
		prog[idx] = instr;
		exp_write[idx] = 1'b0;
		exp_read[idx] = 1'b0;
		exp_addr[idx] = '0;
		exp_wdata[idx] = '0;
		exp_v0[idx] = v0;
		exp_next[idx] = next;
		skipped[idx] = 1'b0;
	endtask

	task skip_row(input integer idx);
		fill_row(idx, encode_itype(6'h09, 5'd0, 5'd2, 16'h0BAD), '0, idx);
		skipped[idx] = 1'b1;
	endtask

	task check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h got %h", name, expected, actual);
			errors++;
		end
	endtask

	task check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h got %h", name, expected, actual);
			errors++;
		end
	endtask

	task load_program;
		fill_row(0, encode_itype(6'h09, 5'd0, 5'd2, 16'h1234), 32'h00001234, 1);	// addiu
		fill_row(1, encode_itype(6'h0D, 5'd0, 5'd3, 16'h80F0), 32'h00001234, 2);	// ori r3
		fill_row(2, encode_itype(6'h0F, 5'd0, 5'd2, 16'h8000), 32'h80000000, 3);	// lui
		fill_row(3, encode_rtype(5'd2, 5'd3, 5'd2, 5'd0, 6'h21), 32'h800080F0, 4);	// addu
		fill_row(4, encode_rtype(5'd2, 5'd3, 5'd2, 5'd0, 6'h23), 32'h80000000, 5);	// subu
		fill_row(5, encode_itype(6'h09, 5'd0, 5'd4, 16'hFFFF), 32'h80000000, 6);	// r4 = -1
		fill_row(6, encode_rtype(5'd2, 5'd4, 5'd2, 5'd0, 6'h24), 32'h80000000, 7);	// and
		fill_row(7, encode_rtype(5'd0, 5'd2, 5'd2, 5'd4, 6'h03), 32'hF8000000, 8);	// sra 4
		fill_row(8, encode_rtype(5'd0, 5'd2, 5'd2, 5'd8, 6'h02), 32'h00F80000, 9);	// srl 8
		fill_row(9, encode_rtype(5'd0, 5'd2, 5'd2, 5'd4, 6'h00), 32'h0F800000, 10);	// sll 4
		fill_row(10, encode_rtype(5'd2, 5'd4, 5'd2, 5'd0, 6'h26), 32'hF07FFFFF, 11);	// xor
		fill_row(11, encode_rtype(5'd2, 5'd3, 5'd2, 5'd0, 6'h2A), 32'h00000001, 12);	// slt
		fill_row(12, encode_rtype(5'd4, 5'd3, 5'd2, 5'd0, 6'h2B), 32'h00000000, 13);	// sltu
		fill_row(13, encode_itype(6'h0A, 5'd4, 5'd2, 16'h0005), 32'h00000001, 14);	// slti
		fill_row(14, encode_itype(6'h2B, 5'd0, 5'd3, 16'h000C), 32'h00000001, 15);	// sw r3
		exp_write[14] = 1'b1;
		exp_addr[14] = 32'h0000000C;
		exp_wdata[14] = 32'h000080F0;
		fill_row(15, encode_itype(6'h23, 5'd0, 5'd2, 16'h000C), 32'h000080F0, 16);	// lw
		exp_read[15] = 1'b1;
		exp_addr[15] = 32'h0000000C;
		fill_row(16, encode_itype(6'h04, 5'd2, 5'd3, 16'h0001), 32'h000080F0, 18);	// beq taken
		skip_row(17);
		fill_row(18, encode_itype(6'h04, 5'd2, 5'd0, 16'h0001), 32'h000080F0, 19);	// beq not
		fill_row(19, encode_itype(6'h05, 5'd2, 5'd0, 16'h0001), 32'h000080F0, 21);	// bne taken
		skip_row(20);
		fill_row(21, encode_jtype(6'h03, 26'h3F00017), 32'h000080F0, 23);	// jal row 23
		skip_row(22);
		fill_row(23, encode_rtype(5'd31, 5'd0, 5'd2, 5'd0, 6'h21), 32'hBFC00058, 24);	// v0 = r31
		fill_row(24, encode_jtype(6'h02, 26'h3F0001A), 32'hBFC00058, 26);	// j row 26
		skip_row(25);
		fill_row(26, encode_rtype(5'd0, 5'd0, 5'd0, 5'd0, 6'h08), 32'hBFC00058, 26);	// jr r0
	endtask

	initial begin : stimulus
		integer i;
		integer idx;
		integer prev_idx;
		logic prev_en;
		logic done;
		word_t prev_pc;
		word_t prev_v0;
		word_t offset;
		seed = 32'h3d35a615;
		errors = 0;
		reset = 1'b1;
		clk_enable = 1'b0;
		instr_readdata = '0;
		data_readdata = '0;
		prev_en = 1'b0;
		for (i = 0; i < 16; i++) begin
			dmem[i] = 32'hD00D0000 | word_t'(i << 2);	// Tagged with byte address
		end
		load_program();
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		prev_idx = -1;
		done = 1'b0;
		while (!done) begin
			if (prev_idx >= 0) begin
				if (prev_en) begin
					check_word("register_v0", exp_v0[prev_idx], register_v0);
					check_word("instr_address",
						reset_vector + word_t'(4 * exp_next[prev_idx]), instr_address);
					if (prev_idx == halt_row) begin
						check_bit("active", 1'b0, active);
						done = 1'b1;
					end
				end else begin
					check_word("instr_address", prev_pc, instr_address);	// Stalled
					check_word("register_v0", prev_v0, register_v0);
				end
			end
			if (!done) begin
				offset = instr_address - reset_vector;
				idx = int'(offset >> 2);
				if (offset >= word_t'(4 * table_len) || offset[1:0] != 2'b00 || skipped[idx]) begin
					$display("Fetch from %h is off the expected program path", instr_address);
					errors++;
					done = 1'b1;
				end else begin
					prev_en = ($random(seed) & 3) != 0;	// About one stall in four
					if ((exp_write[idx] || exp_read[idx]) && idx != prev_idx) begin
						prev_en = 1'b0;	// Memory rows stall on first fetch
					end
					prev_idx = idx;
					prev_pc = instr_address;
					prev_v0 = register_v0;
					clk_enable = prev_en;
					instr_readdata = prog[idx];
					#2;
					data_readdata = dmem[data_address[5:2]];
					#2;
					if (prev_en) begin
						check_bit("data_write", exp_write[idx], data_write);
						check_bit("data_read", exp_read[idx], data_read);
						if (exp_write[idx] || exp_read[idx]) begin
							check_word("data_address", exp_addr[idx], data_address);
						end
						if (exp_write[idx]) begin
							check_word("data_writedata", exp_wdata[idx], data_writedata);
						end
					end else begin
						check_bit("data_write", 1'b0, data_write);
						check_bit("data_read", 1'b0, data_read);
					end
					@(negedge clk);
				end
			end
		end
		clk_enable = 1'b1;
		for (i = 0; i < 4; i++) begin
			instr_readdata = prog[14 + (i % 2)];	// Store, then load, while halted
			#2;
			data_readdata = dmem[data_address[5:2]];
			#2;
			check_bit("data_write", 1'b0, data_write);
			check_bit("data_read", 1'b0, data_read);
			@(negedge clk);
			check_word("instr_address", reset_vector + word_t'(4 * halt_row), instr_address);
			check_word("register_v0", exp_v0[halt_row], register_v0);
			check_bit("active", 1'b0, active);	// Halt is sticky
		end
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("Timeout: core did not reach the halt within %0d ns", watchdog_ns);
		$display("Errors: %0d", errors);
		$display("Test FAILED");
		$finish;
	end

endmodule

// File: all.f
hdl/mips_pkg.sv
hdl/mips_decoder.sv
hdl/mips_regfile.sv
hdl/mips_alu.sv
hdl/mips_fetch.sv
hdl/mips_cpu.sv
verification/mips_cpu_properties.sv
verification/mips_cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mips_cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log
build=obj_dir

verilator --binary --timing --assert \
	--top-module mips_cpu_tb --Mdir "$build" -f all.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build/Vmips_cpu_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Verdict comes from the log, not the exit code alone
if grep -q "^Test OK$" "$log"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
